// File: hw/hptwPkg.sv
/*
  Sv39 page table walker shared definitions
  widths for RV64 with Sv39, walker state encoding, page size
  encoding handed to the TLBs and bit positions inside an entry
*/
package hptwPkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////
  localparam int xlen        = 64; // data and virtual address width
  localparam int paBits      = 56; // physical address width
  localparam int ppnBits     = 44; // physical page number
  localparam int vpnBits     = 9;  // vpn slice per level
  localparam int pteBytesLog = 3;  // 8 byte entries

  // walker states, one adr/rd pair per level
  typedef enum logic [3:0] {
    idle,
    l2Adr,
    l2Rd,
    l1Adr,
    l1Rd,
    l0Adr,
    l0Rd,
    leaf,
    updatePte  // A/D write back to memory
  } walkStateT;

  // page size of the leaf, as the TLBs expect it
  typedef enum logic [1:0] {
    kilo = 2'd0,
    mega = 2'd1,
    giga = 2'd2
  } pageTypeT;

  ////////////////////////////////
  // entry bit positions
  ////////////////////////////////
  localparam int pteIdxV     = 0;
  localparam int pteIdxR     = 1;
  localparam int pteIdxW     = 2;
  localparam int pteIdxX     = 3;
  localparam int pteIdxU     = 4;
  localparam int pteIdxA     = 6;
  localparam int pteIdxD     = 7;
  localparam int pteIdxPpnLo = 10;
  localparam int pteIdxPpnHi = pteIdxPpnLo + ppnBits - 1; // bit 53

endpackage

// File: hw/ptwWalkerFsm.sv
/*
  Page table walker control
  state register and next state logic for a three level Sv39 walk,
  records which TLB missed, pulses the TLB write at the leaf and
  drives the stall and select levels toward the core
*/
`timescale 1ns/1ps

module ptwWalkerFsm import hptwPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      flush,        // kills a walk in flight
  input  logic      itlbMiss,
  input  logic      dtlbMiss,
  input  logic      dcacheStall,
  input  logic      validNonLeaf, // current entry points to another table
  input  logic      updateDa,     // leaf needs A/D written back first
  output walkStateT walkState,
  output logic      dtlbWalk,     // 1 = walk for data side
  output logic      ptwRead,
  output logic      itlbWrite,
  output logic      dtlbWrite,
  output logic      selHptw,
  output logic      hptwStall
);

  walkStateT nextState;
  logic      tlbMiss;
  logic      startWalk;
  logic      tlbWrite;

  assign tlbMiss   = itlbMiss | dtlbMiss;
  assign startWalk = (walkState == idle) & tlbMiss & ~dcacheStall; // same cond as leaving idle

  ////////////////////////////////
  // state register
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      walkState <= idle; // flush drops the walk, no TLB write
    end else begin
      walkState <= nextState;
    end
  end

  // remember the side that missed, held for the whole walk
  always_ff @(posedge clk) begin
    if (!rstN) begin
      dtlbWalk <= 1'b0;
    end else if (startWalk) begin
      dtlbWalk <= dtlbMiss; // data wins if both miss at once
    end
  end

  // read states wait out the cache, adr states decide whether to go deeper
  always_comb begin
    nextState = walkState;
    case (walkState)
      idle:      if (tlbMiss && !dcacheStall) nextState = l2Adr;
      l2Adr:     nextState = l2Rd;                          // root is always read
      l2Rd:      if (!dcacheStall) nextState = l1Adr;
      l1Adr:     nextState = validNonLeaf ? l1Rd : leaf;
      l1Rd:      if (!dcacheStall) nextState = l0Adr;
      l0Adr:     nextState = validNonLeaf ? l0Rd : leaf;
      l0Rd:      if (!dcacheStall) nextState = leaf;        // last level, leaf or not
      leaf:      nextState = updateDa ? updatePte : idle;
      updatePte: if (!dcacheStall) nextState = leaf;        // back to leaf with A/D set
      default:   nextState = idle;
    endcase
  end

  ////////////////////////////////
  // outputs
  ////////////////////////////////
  assign ptwRead = (walkState == l2Rd) | (walkState == l1Rd) | (walkState == l0Rd);

  // TLB write only once memory already holds the final entry
  assign tlbWrite  = (walkState == leaf) & ~updateDa;
  assign itlbWrite = tlbWrite & ~dtlbWalk;
  assign dtlbWrite = tlbWrite & dtlbWalk;

  assign selHptw   = walkState != idle;
  // stall the core as soon as a miss shows up, even before the walk starts
  assign hptwStall = selHptw | ((walkState == idle) & tlbMiss);

endmodule

// File: hw/pteEval.sv
/*
  Page table entry evaluation
  holds the entry fetched on each level, decodes valid/leaf and
  superpage alignment, builds the A/D updated entry and tracks
  the page size for the TLB
*/
`timescale 1ns/1ps

module pteEval import hptwPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  walkStateT       walkState,
  input  logic            ptwRead,
  input  logic            dtlbWalk,
  input  logic            dcacheStall,
  input  logic            writeReq,     // core access is a store
  input  logic [xlen-1:0] readData,     // entry from the cache
  output logic [xlen-1:0] pte,
  output pageTypeT        pageType,
  output logic            validNonLeaf,
  output logic            updateDa,
  output logic            pteWrite
);

  logic               v, r, w, x, a, d;
  logic [ppnBits-1:0] curPpn;
  logic               validPte, leafPte, validLeaf;
  logic               readDone;
  logic               setDirty;
  logic               gigaMis, megaMis;
  logic               misaligned;   // held alongside the entry
  logic [xlen-1:0]    accessedPte;
  logic [xlen-1:0]    nextPte;
  pageTypeT           nextPageType;

  ////////////////////////////////
  // decode
  ////////////////////////////////
  assign v      = pte[pteIdxV];
  assign r      = pte[pteIdxR];
  assign w      = pte[pteIdxW];
  assign x      = pte[pteIdxX];
  assign a      = pte[pteIdxA];
  assign d      = pte[pteIdxD];
  assign curPpn = pte[pteIdxPpnHi:pteIdxPpnLo];

  assign validPte     = v & ~(w & ~r); // W without R is reserved
  assign leafPte      = r | w | x;
  assign validLeaf    = validPte & leafPte;
  assign validNonLeaf = validPte & ~leafPte;

  // superpages need the lower ppn fields zero
  assign gigaMis = |curPpn[2*vpnBits-1:0]; // ppn1, ppn0
  assign megaMis = |curPpn[vpnBits-1:0];   // ppn0

  always_ff @(posedge clk) begin
    if (!rstN) begin
      misaligned <= 1'b0;
    end else if (readDone) begin
      misaligned <= 1'b0;                  // fresh entry, nothing checked yet
    end else if (walkState == l1Adr) begin
      misaligned <= gigaMis;
    end else if (walkState == l0Adr) begin
      misaligned <= megaMis;
    end
  end

  ////////////////////////////////
  // A/D update
  ////////////////////////////////
  assign setDirty = ~d & dtlbWalk & writeReq;
  assign updateDa = (walkState == leaf) & validLeaf & ~misaligned & (~a | setDirty);
  assign pteWrite = walkState == updatePte;

  always_comb begin
    accessedPte          = pte;
    accessedPte[pteIdxA] = 1'b1;
    accessedPte[pteIdxD] = d | setDirty; // D only on a store
  end

  assign readDone = ptwRead & ~dcacheStall;
  assign nextPte  = updateDa ? accessedPte : readData;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pte <= '0;
    end else if (readDone || updateDa) begin
      pte <= nextPte;
    end
  end

  // level of the most recent read is the size if it turns out to be the leaf
  always_comb begin
    case (walkState)
      l2Rd:    nextPageType = giga;
      l1Rd:    nextPageType = mega;
      l0Rd:    nextPageType = kilo;
      default: nextPageType = pageType;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pageType <= kilo;
    end else begin
      pageType <= nextPageType;
    end
  end

endmodule

// File: hw/ptwMemPort.sv
/*
  Walker load/store port
  forms the entry address per level, keeps the leaf address for the
  A/D write back and muxes walker or core requests onto the LSU
*/
`timescale 1ns/1ps

module ptwMemPort import hptwPkg::*; #(
  parameter int pteSize = 3           // funct3 size of a walker access
) (
  input  logic            clk,
  input  logic            rstN,
  input  walkStateT       walkState,
  input  logic            dtlbWalk,
  input  logic            ptwRead,
  input  logic            pteWrite,
  input  logic            selHptw,
  input  logic            itlbWrite,
  input  logic            dtlbWrite,
  input  logic [xlen-1:0] satp,
  input  logic [xlen-1:0] pcSpill,    // fetch address to translate
  input  logic [xlen-1:0] ieuAdr,     // data address to translate
  input  logic [xlen-1:0] writeData,
  input  logic [xlen-1:0] pte,
  input  logic [1:0]      memRw,
  input  logic [2:0]      funct3,
  output logic [xlen-1:0] lsuAdr,
  output logic [xlen-1:0] lsuWriteData,
  output logic [1:0]      lsuRw,
  output logic [2:0]      lsuFunct3
);

  logic [xlen-1:0]    vAdr;
  logic [vpnBits-1:0] vpn;
  logic [ppnBits-1:0] ppn;
  logic [paBits-1:0]  readAdr;
  logic [paBits-1:0]  writeAdr;     // where the leaf came from
  logic [paBits-1:0]  hptwAdr;
  logic               selHptwAdr;
  logic [1:0]         hptwRw;

  assign vAdr = dtlbWalk ? ieuAdr : pcSpill;

  ////////////////////////////////
  // entry address
  ////////////////////////////////
  always_comb begin
    case (walkState)
      l2Adr, l2Rd: vpn = vAdr[38:30];
      l1Adr, l1Rd: vpn = vAdr[29:21];
      default:     vpn = vAdr[20:12];
    endcase
  end

  // root table from satp, deeper tables from the entry just read
  assign ppn = ((walkState == l2Adr) | (walkState == l2Rd)) ?
               satp[ppnBits-1:0] : pte[pteIdxPpnHi:pteIdxPpnLo];
  assign readAdr = {ppn, vpn, {pteBytesLog{1'b0}}};

  // pte is overwritten by each fetch, so keep the last read address
  always_ff @(posedge clk) begin
    if (!rstN) begin
      writeAdr <= '0;
    end else if (ptwRead) begin
      writeAdr <= readAdr;
    end
  end

  assign hptwAdr = pteWrite ? writeAdr : readAdr;
  assign hptwRw  = {ptwRead, pteWrite}; // bit 1 read, bit 0 write

  ////////////////////////////////
  // LSU mux
  ////////////////////////////////
  // core address comes back on the TLB write cycle so the replay sees it
  assign selHptwAdr = selHptw & ~(itlbWrite | dtlbWrite);

  assign lsuAdr       = selHptwAdr ? {{(xlen-paBits){1'b0}}, hptwAdr} : ieuAdr;
  assign lsuRw        = selHptw ? hptwRw : memRw;
  assign lsuFunct3    = selHptw ? 3'(pteSize) : funct3;
  assign lsuWriteData = selHptw ? pte : writeData; // updated entry on write back

endmodule

// File: hw/hptwTop.sv
/*
  Sv39 hardware page table walker
  walks up to three levels on an I or D TLB miss through the data
  cache port, sets A/D in memory when needed and fills the TLB
*/
`timescale 1ns/1ps

module hptwTop import hptwPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            flush,
  input  logic            itlbMiss,
  input  logic            dtlbMiss,
  input  logic            dcacheStall,
  input  logic [xlen-1:0] satp,
  input  logic [xlen-1:0] pcSpill,
  input  logic [xlen-1:0] ieuAdr,
  input  logic [xlen-1:0] writeData,
  input  logic [xlen-1:0] readData,
  input  logic [1:0]      memRw,
  input  logic [2:0]      funct3,
  output logic [xlen-1:0] pte,          // entry for the TLB
  output pageTypeT        pageType,
  output logic            itlbWrite,
  output logic            dtlbWrite,
  output logic            selHptw,
  output logic            hptwStall,
  output logic [xlen-1:0] lsuAdr,
  output logic [xlen-1:0] lsuWriteData,
  output logic [1:0]      lsuRw,
  output logic [2:0]      lsuFunct3
);

  walkStateT walkState;
  logic      dtlbWalk;
  logic      ptwRead;
  logic      validNonLeaf;
  logic      updateDa;
  logic      pteWrite;

  ptwWalkerFsm walkerFsm (
    .clk, .rstN, .flush, .itlbMiss, .dtlbMiss, .dcacheStall,
    .validNonLeaf, .updateDa,
    .walkState, .dtlbWalk, .ptwRead, .itlbWrite, .dtlbWrite,
    .selHptw, .hptwStall
  );

  pteEval pteEvalU (
    .clk, .rstN, .walkState, .ptwRead, .dtlbWalk, .dcacheStall,
    .writeReq(memRw[0]),  // store side of the core request
    .readData,
    .pte, .pageType, .validNonLeaf, .updateDa, .pteWrite
  );

  // doubleword entries on RV64
  ptwMemPort #(.pteSize(3)) memPort (
    .clk, .rstN, .walkState, .dtlbWalk, .ptwRead, .pteWrite,
    .selHptw, .itlbWrite, .dtlbWrite,
    .satp, .pcSpill, .ieuAdr, .writeData, .pte, .memRw, .funct3,
    .lsuAdr, .lsuWriteData, .lsuRw, .lsuFunct3
  );

endmodule

// File: tests/hptwTop_assert.sv
/*
  Walker protocol assertions
  bound into hptwTop to watch the end of each fill, the stall level
  and what the walker stores on the LSU port
*/
`timescale 1ns/1ps

module hptwTopAssert import hptwPkg::*; (
  input logic            clk,
  input logic            rstN,
  input logic            itlbWrite,
  input logic            dtlbWrite,
  input logic            selHptw,
  input logic            hptwStall,
  input logic [1:0]      lsuRw,
  input logic [xlen-1:0] lsuWriteData  // entry on the A/D write back
);

  // the port goes back to the core right after a fill
  tlbWriteEndsWalk: assert property (@(posedge clk) disable iff (!rstN)
    (itlbWrite || dtlbWrite) |=> !selHptw)
    else $error("walker still selected after a TLB write");

  // core already stalled in the cycle the walk gets accepted
  stallBeforeSelect: assert property (@(posedge clk) disable iff (!rstN)
    $rose(selHptw) |-> $past(hptwStall))
    else $error("walker selected without stalling the core first");

  // walker only stores an entry that is marked accessed
  writeMarksAccessed: assert property (@(posedge clk) disable iff (!rstN)
    (selHptw && lsuRw == 2'b01) |-> lsuWriteData[pteIdxA])
    else $error("walker write without the accessed bit set");

endmodule

bind hptwTop hptwTopAssert hptwTopAssertU (
  .clk(clk), .rstN(rstN), .itlbWrite(itlbWrite), .dtlbWrite(dtlbWrite),
  .selHptw(selHptw), .hptwStall(hptwStall), .lsuRw(lsuRw),
  .lsuWriteData(lsuWriteData)
);

// File: tests/hptwTb.sv
/*
  Sv39 walker testbench
  random page tables in a sparse memory with random cache stalls,
  walks on I and D misses checked against a reference walk, plus
  idle passthrough and flush during a walk
*/
`timescale 1ns/1ps

module hptwTb import hptwPkg::*; ();

  localparam int seedInit = 32'h4eb4_2e5b;

  logic clk, rstN, flush, itlbMiss, dtlbMiss, dcacheStall;
  logic [xlen-1:0] satp, pcSpill, ieuAdr, writeData, readData;
  logic [1:0] memRw;
  logic [2:0] funct3;
  logic [xlen-1:0] pte, lsuAdr, lsuWriteData;
  pageTypeT pageType;
  logic itlbWrite, dtlbWrite, selHptw, hptwStall;
  logic [1:0] lsuRw;
  logic [2:0] lsuFunct3;

  integer seed = seedInit;
  integer stallSeed = seedInit ^ 32'h0000_ffff; // own stream for the cache
  logic [63:0] mem [logic [63:0]];             // sparse backing store
  logic [63:0] rdAdrQ[$], wrAdrQ[$], wrDataQ[$], expRdQ[$];
  logic [63:0] satpVal, vaVal, expPte, expLeafAdr;
  int expType;
  bit expUpd;
  int errCount = 0, checkCount = 0, testCount = 0, errAtStart;

  hptwTop UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic checkVal(input string name, input logic [63:0] expVal,
                          input logic [63:0] actVal);
    checkCount++;
    if (expVal !== actVal) begin
      errCount++;
      $display("** Error %s: expected %h, actual %h", name, expVal, actVal);
    end
  endtask

  task automatic endTest(input string name);
    testCount++;
    $display("%-18s %s", name, (errCount == errAtStart) ? "ok" : "failed");
  endtask

  function automatic logic [63:0] memRead(input logic [63:0] adr);
    if (mem.exists(adr)) return mem[adr];
    return {adr[31:0], adr[63:32]} ^ 64'h9e37_79b9_7f4a_7c15; // unwritten words
  endfunction

  function automatic logic [8:0] vpnOf(input logic [63:0] va, input int lvl);
    return va[12 + 9*lvl +: 9];
  endfunction

  function automatic logic [63:0] pteAdr(input logic [43:0] ppn, input logic [8:0] vpn);
    return {8'h0, ppn, vpn, 3'b000}; // 8 byte entries
  endfunction

  //////////////////////////////
  // tables and reference walk
  //////////////////////////////
  // pointers down to leafLvl with random leaf bits unless an update is forced
  task automatic buildTable(input bit forceUpd, input bit deepest);
    logic [43:0] ppn, nextPpn;
    logic [63:0] ent;
    logic [31:0] bits;
    int leafLvl;
    mem.delete();
    vaVal   = {$random(seed), $random(seed)};
    ppn     = {$random(seed), $random(seed)};
    satpVal = {4'h8, 16'h0, ppn}; // mode Sv39
    leafLvl = deepest ? 0 : {$random(seed)} % 3;
    for (int lvl = 2; lvl >= leafLvl; lvl--) begin
      nextPpn = {$random(seed), $random(seed)};
      bits    = $random(seed);
      if (lvl > leafLvl) begin
        ent = {10'h0, nextPpn, 10'h001}; // valid pointer
      end else begin
        if (bits[8] || forceUpd) begin   // superpage aligned
          if (lvl == 2) nextPpn[17:0] = '0;
          if (lvl == 1) nextPpn[8:0] = '0;
        end
        ent    = {10'h0, nextPpn, bits[9:8], bits[7:0]};
        ent[0] = |bits[11:10];           // mostly valid
        if (forceUpd) begin
          ent[3:0] = 4'b0111;            // V R W
          ent[7:6] = 2'b00;              // A, D clear
        end
      end
      mem[pteAdr(ppn, vpnOf(vaVal, lvl))] = ent;
      ppn = nextPpn;
    end
  endtask

  task automatic modelWalk(input bit dSide, input bit store);
    logic [43:0] ppn;
    logic [63:0] adr, ent;
    int lvl;
    bit valid, isLeaf, mis, setD;
    expRdQ.delete();
    ppn = satpVal[43:0];
    lvl = 2;
    adr = pteAdr(ppn, vpnOf(vaVal, lvl));
    expRdQ.push_back(adr);
    ent    = memRead(adr);
    valid  = ent[0] && !(ent[2] && !ent[1]); // W without R reserved
    isLeaf = |ent[3:1];
    while (lvl > 0 && valid && !isLeaf) begin
      lvl--;
      ppn = ent[53:10];
      adr = pteAdr(ppn, vpnOf(vaVal, lvl));
      expRdQ.push_back(adr);
      ent    = memRead(adr);
      valid  = ent[0] && !(ent[2] && !ent[1]);
      isLeaf = |ent[3:1];
    end
    mis = (lvl == 2) ? |ent[27:10] : (lvl == 1) ? |ent[18:10] : 1'b0;
    setD   = !ent[7] && dSide && store;
    expUpd = valid && isLeaf && !mis && (!ent[6] || setD);
    expPte = ent;
    if (expUpd) begin
      expPte[6] = 1'b1;
      expPte[7] = ent[7] | setD;
    end
    expType    = lvl; // giga 2, mega 1, kilo 0
    expLeafAdr = adr;
  endtask

  //////////////////////////////
  // cache model, stalls and port monitor
  //////////////////////////////
  initial begin
    logic prevStalled;
    logic [63:0] prevAdr;
    readData    = '0;
    dcacheStall = 1'b0;
    prevStalled = 1'b0;
    prevAdr     = '0;
    forever begin
      @(posedge clk);
      if (rstN && selHptw) begin
        if (prevStalled && lsuRw == 2'b10)
          checkVal("read address held", prevAdr, lsuAdr);
        if (lsuRw != 2'b00)
          checkVal("walker lsuFunct3", 3, lsuFunct3); // doubleword entries
        if (lsuRw == 2'b10 && !dcacheStall) rdAdrQ.push_back(lsuAdr);
        if (lsuRw == 2'b01 && !dcacheStall) begin
          mem[lsuAdr] = lsuWriteData;
          wrAdrQ.push_back(lsuAdr);
          wrDataQ.push_back(lsuWriteData);
        end
      end
      prevStalled = rstN && selHptw && lsuRw == 2'b10 && dcacheStall;
      prevAdr     = lsuAdr;
      readData    <= memRead(lsuAdr);                // one cycle read
      dcacheStall <= ({$random(stallSeed)} % 4) == 0; // about one in four
    end
  end

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic idleCheck();
    errAtStart = errCount;
    for (int i = 0; i < 8; i++) begin
      ieuAdr    <= {$random(seed), $random(seed)};
      writeData <= {$random(seed), $random(seed)};
      memRw     <= $random(seed);
      funct3    <= $random(seed);
      @(posedge clk);
      checkVal("idle selHptw", 0, selHptw);
      checkVal("idle hptwStall", 0, hptwStall);
      checkVal("idle tlb writes", 0, {itlbWrite, dtlbWrite});
      checkVal("idle lsuAdr", ieuAdr, lsuAdr);
      checkVal("idle lsuRw", memRw, lsuRw);
      checkVal("idle lsuFunct3", funct3, lsuFunct3);
      checkVal("idle lsuWriteData", writeData, lsuWriteData);
    end
    endTest("idleCheck");
  endtask

  task automatic runWalk(input string name, input bit dSide, input bit store,
                         input bit forceUpd);
    bit seen;
    int stallDrops;
    logic [63:0] gotPte;
    logic [1:0] gotType;
    logic gotI, gotD;
    errAtStart = errCount;
    buildTable(forceUpd, 1'b0);
    modelWalk(dSide, store);
    rdAdrQ.delete();
    wrAdrQ.delete();
    wrDataQ.delete();
    satp     <= satpVal;
    pcSpill  <= dSide ? {$random(seed), $random(seed)} : vaVal;
    ieuAdr   <= dSide ? vaVal : {$random(seed), $random(seed)};
    memRw    <= store ? 2'b01 : 2'b10;
    itlbMiss <= !dSide;
    dtlbMiss <= dSide;
    seen       = 1'b0;
    stallDrops = 0;
    for (int cycles = 0; cycles < 400 && !seen; cycles++) begin
      @(posedge clk);
      if (!hptwStall) stallDrops++; // miss pending or walk busy the whole time
      if (itlbWrite || dtlbWrite) begin
        seen    = 1'b1;
        gotPte  = pte;
        gotType = pageType;
        gotI    = itlbWrite;
        gotD    = dtlbWrite;
        itlbMiss <= 1'b0; // miss served so the TLB now hits
        dtlbMiss <= 1'b0;
      end
    end
    if (!seen) begin
      errCount++;
      $display("%s: walk timed out, no TLB write within 400 cycles", name);
      itlbMiss <= 1'b0;
      dtlbMiss <= 1'b0;
    end else begin
      checkVal({name, " itlbWrite"}, !dSide, gotI);
      checkVal({name, " dtlbWrite"}, dSide, gotD);
      checkVal({name, " pageType"}, expType, gotType);
      checkVal({name, " pte"}, expPte, gotPte);
      checkVal({name, " hptwStall low"}, 0, stallDrops);
      checkVal({name, " read count"}, expRdQ.size(), rdAdrQ.size());
      for (int i = 0; i < expRdQ.size() && i < rdAdrQ.size(); i++)
        checkVal($sformatf("%s read %0d", name, i), expRdQ[i], rdAdrQ[i]);
      checkVal({name, " write count"}, expUpd, wrAdrQ.size());
      if (expUpd && wrAdrQ.size() == 1) begin
        checkVal({name, " write address"}, expLeafAdr, wrAdrQ[0]);
        checkVal({name, " write data"}, expPte, wrDataQ[0]);
      end
    end
    @(posedge clk);
    checkVal({name, " back to idle"}, 0, selHptw);
    endTest(name);
  endtask

  // kill a three level walk early and make sure no TLB gets filled
  task automatic flushWalk();
    bit started;
    bit selAfter;
    int tlbWrites;
    errAtStart = errCount;
    started    = 1'b0;
    selAfter   = 1'b0;
    tlbWrites  = 0;
    buildTable(1'b0, 1'b1);
    satp     <= satpVal;
    pcSpill  <= vaVal;
    itlbMiss <= 1'b1;
    for (int cycles = 0; cycles < 100 && !started; cycles++) begin
      @(posedge clk);
      started = selHptw;
    end
    if (!started) begin
      errCount++;
      $display("flushWalk: walk did not start within 100 cycles");
    end
    @(posedge clk);
    tlbWrites += itlbWrite + dtlbWrite;
    flush    <= 1'b1;
    itlbMiss <= 1'b0;
    @(posedge clk);
    tlbWrites += itlbWrite + dtlbWrite;
    flush <= 1'b0;
    @(posedge clk);
    checkVal("flush selHptw", 0, selHptw);
    // a walk that survived the flush would reach its leaf in this window
    for (int cycles = 0; cycles < 40; cycles++) begin
      @(posedge clk);
      tlbWrites += itlbWrite + dtlbWrite;
      selAfter  |= selHptw;
    end
    checkVal("flush stays idle", 0, selAfter);
    checkVal("flush tlb writes", 0, tlbWrites);
    endTest("flushWalk");
  endtask

  initial begin
    rstN      <= 1'b0;
    flush     <= 1'b0;
    itlbMiss  <= 1'b0;
    dtlbMiss  <= 1'b0;
    satp      <= '0;
    pcSpill   <= '0;
    ieuAdr    <= '0;
    writeData <= '0;
    memRw     <= 2'b00;
    funct3    <= 3'b000;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    idleCheck();
    for (int i = 0; i < 6; i++) runWalk($sformatf("iWalk%0d", i), 1'b0, $random(seed), 1'b0);
    runWalk("dStoreUpdate", 1'b1, 1'b1, 1'b1);
    runWalk("dLoadUpdate", 1'b1, 1'b0, 1'b1);
    for (int i = 0; i < 6; i++) runWalk($sformatf("dWalk%0d", i), 1'b1, $random(seed), 1'b0);
    flushWalk();
    runWalk("walkAfterFlush", 1'b0, 1'b0, 1'b0);
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/hptwPkg.sv
hw/ptwWalkerFsm.sv
hw/pteEval.sv
hw/ptwMemPort.sv
hw/hptwTop.sv
tests/hptwTop_assert.sv
tests/hptwTb.sv

// File: Bender.yml
package:
  name: hptw

sources:
  - hw/hptwPkg.sv
  - hw/ptwWalkerFsm.sv
  - hw/pteEval.sv
  - hw/ptwMemPort.sv
  - hw/hptwTop.sv
  - target: test
    files:
      - tests/hptwTop_assert.sv
      - tests/hptwTb.sv
